/* Makefile */
SOURCES := $(shell grep -v '^+' list.f) include/bridge_cfg.svh

.PHONY: run clean

run: obj_dir/Vtb_byte_word_bridge
	@out="$$(./obj_dir/Vtb_byte_word_bridge)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

obj_dir/Vtb_byte_word_bridge: list.f $(SOURCES)
	verilator --binary --timing -Wno-fatal -f list.f \
		--top-module tb_byte_word_bridge -Mdir obj_dir -o Vtb_byte_word_bridge

clean:
	rm -rf obj_dir

/* hdl/byte_word_bridge.sv */
`timescale 1ns/1ps
`include "bridge_cfg.svh"

module byte_word_bridge (
   input  logic                          clk,
   input  logic                          rst_n,

   // producer side
   input  logic                          w_en,
   input  fifo_pkg::byte_t               w_data,
   output logic                          w_full,
   output logic [`BRIDGE_ADDR_W:0]       level,

   // consumer side
   output link_pkg::link_beat_t          beat,
   input  logic                          credit_return
);

   import link_pkg::*;

   logic                             r_en;
   logic                             r_empty;
   logic [`BRIDGE_R_DATA_W-1:0]      r_data;
   credit_t                          credits;

   fifo_sync_asym #(
      .ADDR_W (`BRIDGE_ADDR_W)
   ) fifo_sync_asym_inst (
      .clk     (clk),
      .rst_n   (rst_n),
      .w_en    (w_en),
      .w_data  (w_data),
      .w_full  (w_full),
      .r_en    (r_en),
      .r_data  (r_data),
      .r_empty (r_empty),
      .level   (level)
   );

   drain_ctrl drain_ctrl_inst (
      .clk     (clk),
      .rst_n   (rst_n),
      .r_empty (r_empty),
      .credits (credits),
      .r_data  (r_data),
      .r_en    (r_en),
      .beat    (beat)
   );

   // each pop consumes one credit
   credit_counter credit_counter_inst (
      .clk           (clk),
      .rst_n         (rst_n),
      .credit_return (credit_return),
      .consume       (r_en),
      .credits       (credits)
   );

endmodule

/* hdl/credit_counter.sv */
`timescale 1ns/1ps
`include "bridge_cfg.svh"

module credit_counter (
   input  logic              clk,
   input  logic              rst_n,

   // one pulse returns one credit
   input  logic              credit_return,

   // one pop takes one credit
   input  logic              consume,

   output link_pkg::credit_t credits
);

   import link_pkg::*;

   localparam credit_t MAX_CREDITS = `BRIDGE_MAX_CREDITS;

   // return and consume in the same cycle cancel out
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         credits <= MAX_CREDITS;
      end else begin
         case ({credit_return, consume})
            2'b10: begin
               // saturate, extra returns are ignored
               if (credits != MAX_CREDITS) begin
                  credits <= credits + 1'b1;
               end
            end
            2'b01: begin
               if (credits != '0) begin
                  credits <= credits - 1'b1;
               end
            end
            default: begin
               credits <= credits;
            end
         endcase
      end
   end

endmodule

/* hdl/drain_ctrl.sv */
`timescale 1ns/1ps
`include "bridge_cfg.svh"

module drain_ctrl (
   input  logic                             clk,
   input  logic                             rst_n,

   // FIFO status and credit count
   input  logic                             r_empty,
   input  link_pkg::credit_t                credits,

   // popped word, valid one cycle after the pop
   input  logic [`BRIDGE_R_DATA_W-1:0]      r_data,

   // pop request, also reserves a credit
   output logic                             r_en,

   // beat towards the consumer
   output link_pkg::link_beat_t             beat
);

   import link_pkg::*;

   drain_state_e state;
   drain_state_e state_nxt;
   logic         can_pop;
   logic         beat_valid;

   // a whole word is stored and a credit is free
   assign can_pop = ~r_empty & (credits != '0);

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE: begin
            if (can_pop) begin
               state_nxt = STREAM;
            end
         end
         STREAM: begin
            // out of data or out of credits
            if (!can_pop) begin
               state_nxt = IDLE;
            end
         end
         default: begin
            state_nxt = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // pop every cycle while streaming and allowed
   assign r_en = (state == STREAM) & can_pop;

   // word arrives from the memory one cycle after the pop
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         beat_valid <= 1'b0;
      end else begin
         beat_valid <= r_en;
      end
   end

   assign beat.valid = beat_valid;
   assign beat.data  = r_data;

endmodule

/* hdl/fifo_pkg.sv */
`include "bridge_cfg.svh"

package fifo_pkg;

   // one write lane
   typedef logic [`BRIDGE_W_DATA_W-1:0] byte_t;

   // one read lane
   typedef logic [`BRIDGE_R_DATA_W-1:0] word_t;

   // one memory entry, seen as a word or as its byte lanes
   // lane 0 holds the least significant byte, the first one written
   typedef union packed {
      word_t                          word;
      byte_t [`BRIDGE_LANES-1:0]      lanes;
   } mem_word_u;

endpackage

/* hdl/fifo_sync_asym.sv */
`timescale 1ns/1ps
`include "bridge_cfg.svh"

module fifo_sync_asym #(
   parameter int ADDR_W = `BRIDGE_ADDR_W
) (
   input  logic                             clk,
   input  logic                             rst_n,

   // write side, one byte per accepted write
   input  logic                             w_en,
   input  fifo_pkg::byte_t                  w_data,
   output logic                             w_full,

   // read side, one word per accepted read
   input  logic                             r_en,
   output logic [`BRIDGE_R_DATA_W-1:0]      r_data,
   output logic                             r_empty,

   // fill level in bytes
   output logic [ADDR_W:0]                  level
);

   localparam int LANE_W   = $clog2(`BRIDGE_LANES);
   localparam int R_ADDR_W = ADDR_W - LANE_W;

   localparam logic [ADDR_W:0] FIFO_SIZE   = 1 << ADDR_W;
   localparam logic [ADDR_W:0] W_INCR      = 1;
   localparam logic [ADDR_W:0] R_INCR      = `BRIDGE_LANES;
   localparam logic [ADDR_W:0] FULL_THRESH = FIFO_SIZE - R_INCR;

   logic                  w_en_int;
   logic                  r_en_int;
   logic [ADDR_W-1:0]     w_addr;
   logic [R_ADDR_W-1:0]   r_addr;
   logic [ADDR_W:0]       level_nxt;

   // only act on requests the flags allow
   assign w_en_int = w_en & ~w_full;
   assign r_en_int = r_en & ~r_empty;

   // byte write address
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         w_addr <= '0;
      end else if (w_en_int) begin
         w_addr <= w_addr + 1'b1;
      end
   end

   // word read address
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         r_addr <= '0;
      end else if (r_en_int) begin
         r_addr <= r_addr + 1'b1;
      end
   end

   // +1 per byte in, -4 per word out, both may happen together
   always_comb begin
      level_nxt = level;
      if (w_en_int) begin
         level_nxt = level_nxt + W_INCR;
      end
      if (r_en_int) begin
         level_nxt = level_nxt - R_INCR;
      end
   end

   // level and flags, flags come from the next level
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         level   <= '0;
         r_empty <= 1'b1;
         w_full  <= 1'b0;
      end else begin
         level   <= level_nxt;
         // less than one whole word stored
         r_empty <= level_nxt < R_INCR;
         w_full  <= level_nxt > FULL_THRESH;
      end
   end

   ram_2p_asym ram_2p_asym_inst (
      .clk    (clk),
      .w_en   (w_en_int),
      .w_addr (w_addr),
      .w_data (w_data),
      .r_en   (r_en_int),
      .r_addr (r_addr),
      .r_data (r_data)
   );

endmodule

/* hdl/link_pkg.sv */
`include "bridge_cfg.svh"

package link_pkg;

   // credit count for the output link
   typedef logic [`BRIDGE_CRED_W-1:0] credit_t;

   // one beat sent downstream
   typedef struct packed {
      logic                          valid;
      logic [`BRIDGE_R_DATA_W-1:0]   data;
   } link_beat_t;

   // drain controller states
   typedef enum logic {
      IDLE   = 1'b0,
      STREAM = 1'b1
   } drain_state_e;

endpackage

/* hdl/ram_2p_asym.sv */
`timescale 1ns/1ps
`include "bridge_cfg.svh"

module ram_2p_asym (
   input  logic                             clk,

   // byte write port
   input  logic                             w_en,
   input  logic [`BRIDGE_ADDR_W-1:0]        w_addr,
   input  fifo_pkg::byte_t                  w_data,

   // word read port
   input  logic                             r_en,
   input  logic [`BRIDGE_ADDR_W-3:0]        r_addr,
   output logic [`BRIDGE_R_DATA_W-1:0]      r_data
);

   import fifo_pkg::*;

   localparam int LANE_W = $clog2(`BRIDGE_LANES);
   localparam int DEPTH  = 1 << (`BRIDGE_ADDR_W - LANE_W);

   // storage, one word per entry
   mem_word_u mem [0:DEPTH-1];

   // byte write, lane from the low address bits
   always_ff @(posedge clk) begin
      if (w_en) begin
         mem[w_addr[`BRIDGE_ADDR_W-1:LANE_W]].lanes[w_addr[LANE_W-1:0]] <= w_data;
      end
   end

   // registered word read, holds when not enabled
   always_ff @(posedge clk) begin
      if (r_en) begin
         r_data <= mem[r_addr].word;
      end
   end

endmodule

/* include/bridge_cfg.svh */
`ifndef BRIDGE_CFG_SVH
`define BRIDGE_CFG_SVH

// byte address width of the FIFO, 64 bytes of storage
`define BRIDGE_ADDR_W 6

// write lane and read lane widths
`define BRIDGE_W_DATA_W 8
`define BRIDGE_R_DATA_W 32

// bytes per memory word
`define BRIDGE_LANES (`BRIDGE_R_DATA_W / `BRIDGE_W_DATA_W)

// credits granted to the output link at reset
`define BRIDGE_MAX_CREDITS 4

// width of the credit count, must hold BRIDGE_MAX_CREDITS
`define BRIDGE_CRED_W 3

`endif

/* list.f */
+incdir+include
hdl/fifo_pkg.sv
hdl/link_pkg.sv
hdl/ram_2p_asym.sv
hdl/fifo_sync_asym.sv
hdl/credit_counter.sv
hdl/drain_ctrl.sv
hdl/byte_word_bridge.sv
tb/tb_byte_word_bridge.sv

/* tb/tb_byte_word_bridge.sv */
`timescale 1ns/1ps
`include "bridge_cfg.svh"

module tb_byte_word_bridge;

   import fifo_pkg::*;
   import link_pkg::*;

   localparam int RANDOM_BYTES = 300;
   // packing + credit limit + fill up to 64 + partial word + random stream
   localparam int TOTAL_BYTES  = 8 + 40 + 64 + 2 + RANDOM_BYTES;
   localparam int CYCLE_LIMIT  = 10 * TOTAL_BYTES + 500;

   logic                    clk;
   logic                    rst_n;
   logic                    w_en;
   byte_t                   w_data;
   logic                    w_full;
   logic [`BRIDGE_ADDR_W:0] level;
   link_beat_t              beat;
   logic                    credit_return;

   // bytes accepted by the FIFO and not yet matched by a beat
   byte_t       model_q[$];
   byte_t       pack_bytes [8] = '{8'h01, 8'h23, 8'h45, 8'h67, 8'h89, 8'hab, 8'hcd, 8'hef};
   logic [31:0] rng_state;
   logic [31:0] exp_word;
   string       test_name;
   int          errors         = 0;
   int          cycles         = 0;
   int          beats_seen     = 0;
   int          returns_seen   = 0;
   int          returns_sent   = 0;
   int          bytes_accepted = 0;

   byte_word_bridge byte_word_bridge_inst (
      .clk           (clk),
      .rst_n         (rst_n),
      .w_en          (w_en),
      .w_data        (w_data),
      .w_full        (w_full),
      .level         (level),
      .beat          (beat),
      .credit_return (credit_return)
   );

   always #4 clk = ~clk;

   function automatic logic [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   // next four model bytes with the first one in the low lane
   function automatic logic [31:0] expected_word();
      logic [31:0] word;
      word = '0;
      for (int k = 0; k < 4; k++) begin
         word[8*k +: 8] = model_q.pop_front();
      end
      return word;
   endfunction

   task automatic check(input string what, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (expected !== actual) begin
         $display("[ERROR] %s: %s expected 0x%08h actual 0x%08h",
                  test_name, what, expected, actual);
         errors = errors + 1;
      end
   endtask

   // drive one falling edge and write only while w_full is low
   task automatic drive_cycle(input logic want_write, input byte_t data,
                              input logic want_return, output logic accepted);
      @(negedge clk);
      accepted      = want_write && !w_full;
      w_en          = accepted;
      w_data        = data;
      // return credits only for beats already received
      credit_return = want_return && (returns_sent < beats_seen);
      if (accepted) begin
         model_q.push_back(data);
         bytes_accepted = bytes_accepted + 1;
      end
      if (credit_return) begin
         returns_sent = returns_sent + 1;
      end
   endtask

   task automatic write_byte(input byte_t data);
      logic acc;
      acc = 1'b0;
      while (!acc) begin
         drive_cycle(1'b1, data, 1'b0, acc);
      end
   endtask

   task automatic idle(input int n);
      logic acc;
      repeat (n) drive_cycle(1'b0, '0, 1'b0, acc);
   endtask

   task automatic wait_beats(input int target);
      logic acc;
      while (beats_seen < target) begin
         drive_cycle(1'b0, '0, 1'b0, acc);
      end
   endtask

   task automatic return_all();
      logic acc;
      while (returns_sent < beats_seen) begin
         drive_cycle(1'b0, '0, 1'b1, acc);
      end
   endtask

   // keep returning credits until every whole word has arrived
   task automatic drain_words();
      logic acc;
      while (model_q.size() >= 4) begin
         drive_cycle(1'b0, '0, 1'b1, acc);
      end
   endtask

   // check beats against the model and count returns after them
   always @(posedge clk) begin
      if (rst_n) begin
         if (beat.valid) begin
            if (model_q.size() < 4) begin
               $display("beat arrived while the reference model holds no whole word");
               errors = errors + 1;
            end else begin
               exp_word = expected_word();
               check("beat data", exp_word, beat.data);
            end
            beats_seen = beats_seen + 1;
            if (beats_seen - returns_seen > `BRIDGE_MAX_CREDITS) begin
               $display("credit rule broken, %0d beats outstanding with a limit of %0d",
                        beats_seen - returns_seen, `BRIDGE_MAX_CREDITS);
               errors = errors + 1;
            end
         end
         if (credit_return) begin
            returns_seen = returns_seen + 1;
         end
      end
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > CYCLE_LIMIT) begin
         $display("timeout after %0d cycles, the stream did not finish", CYCLE_LIMIT);
         $display("errors: %0d  beats: %0d  bytes: %0d", errors + 1, beats_seen,
                  bytes_accepted);
         $display("Result: FAILED");
         $finish;
      end
   end

   initial begin
      logic [31:0] rnd;
      logic        acc;
      int          start;
      int          fill_level;
      int          written;

      clk           = 1'b0;
      rst_n         = 1'b0;
      w_en          = 1'b0;
      w_data        = '0;
      credit_return = 1'b0;
      rng_state     = 32'd71480;

      test_name = "reset state";
      repeat (3) @(negedge clk);
      check("beat valid", 32'(0), 32'(beat.valid));
      check("w_full", 32'(0), 32'(w_full));
      check("level", 32'(0), 32'(level));
      rst_n = 1'b1;

      test_name = "byte packing";
      start = beats_seen;
      for (int i = 0; i < 8; i++) begin
         write_byte(pack_bytes[i]);
      end
      wait_beats(start + 2);
      return_all();
      idle(10);
      check("beat count", 32'(start + 2), 32'(beats_seen));

      test_name = "credit limit";
      start = beats_seen;
      for (int i = 0; i < 40; i++) begin
         rnd = next_rand();
         write_byte(rnd[7:0]);
      end
      wait_beats(start + 4);
      idle(50);
      check("beats without returns", 32'(start + 4), 32'(beats_seen));
      for (int i = 1; i <= 2; i++) begin
         drive_cycle(1'b0, '0, 1'b1, acc);
         wait_beats(start + 4 + i);
         idle(10);
         check("beats after one return", 32'(start + 4 + i), 32'(beats_seen));
      end

      // no credits left so nothing leaves the FIFO
      test_name = "full flag and level";
      check("quiet level", 32'(bytes_accepted - 4 * beats_seen), 32'(level));
      acc = 1'b1;
      while (acc) begin
         rnd = next_rand();
         drive_cycle(1'b1, rnd[7:0], 1'b0, acc);
         // a write in this cycle is not visible yet
         fill_level = bytes_accepted - 4 * beats_seen - int'(acc);
         check("level while filling", 32'(fill_level), 32'(level));
         check("w_full while filling", 32'(fill_level > 60), 32'(w_full));
      end
      idle(5);
      check("level when full", 32'(61), 32'(level));
      check("w_full when full", 32'(1), 32'(w_full));
      drain_words();
      return_all();
      idle(10);

      test_name = "partial word";
      start = beats_seen;
      while (model_q.size() < 3) begin
         rnd = next_rand();
         write_byte(rnd[7:0]);
      end
      idle(20);
      check("beats from partial word", 32'(start), 32'(beats_seen));
      check("partial level", 32'(3), 32'(level));

      test_name = "random stream";
      written = 0;
      while (written < RANDOM_BYTES) begin
         rnd = next_rand();
         drive_cycle(rnd[0], rnd[15:8], rnd[1], acc);
         if (acc) begin
            written = written + 1;
         end
      end
      drain_words();
      return_all();
      idle(10);
      // the whole stream leaves only its last partial word behind
      check("leftover level", 32'(bytes_accepted % 4), 32'(level));
      check("beats in total", 32'(bytes_accepted / 4), 32'(beats_seen));

      $display("errors: %0d  beats: %0d  bytes: %0d", errors, beats_seen, bytes_accepted);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule
